//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps -f src.f \
  --top-module tge_cpu_attach_tb -o tb_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held for 16 rising edges
  initial begin
    rst_o = 1'b1;
    repeat (16) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- sim/tge_cpu_attach_assert.sv
`timescale 1ns/10ps

module tge_cpu_attach_assert (
  input logic wb_clk_i,
  input logic wb_rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic ack_i,
  input logic tx_we_i,
  input logic rx_we_i
);

  logic trans;

  assign trans = wb_stb_i & wb_cyc_i & ~ack_i;

  // acknowledge is a single pulse
  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else $error("acknowledge held for two cycles");

  ack_follows: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    trans |=> ack_i)
    else $error("transaction not acknowledged in the next cycle");

  // tx and rx windows never overlap
  we_exclusive: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(tx_we_i && rx_we_i))
    else $error("tx and rx write strobes high together");

endmodule

bind tge_wb_decode tge_cpu_attach_assert decode_checks (
  .wb_clk_i(wb_clk_i),
  .wb_rst_i(wb_rst_i),
  .wb_cyc_i(wb_cyc_i),
  .wb_stb_i(wb_stb_i),
  .ack_i(ack_o),
  .tx_we_i(tx_we_o),
  .rx_we_i(rx_we_o)
);

//--- sim/tge_cpu_attach_tb.sv
`timescale 1ns/10ps

module tge_cpu_attach_tb;
  import tge_cpu_pkg::*;

  localparam int BUS_TIMEOUT = 20;
  localparam int HS_TIMEOUT  = 40;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [15:0] wb_dat_w;
  logic [15:0] wb_dat_r;
  logic        wb_ack;
  logic [47:0] local_mac;
  logic [31:0] local_ip;
  logic [7:0]  local_gateway;
  logic [15:0] local_port;
  logic        local_valid;
  logic [7:0]  phy_status;
  logic [1:0]  mgt_rxeqmix;
  logic [3:0]  mgt_rxeqpole;
  logic [2:0]  mgt_txpreemphasis;
  logic [2:0]  mgt_txdiffctrl;
  logic [63:0] tx_din;
  logic [8:0]  tx_adr;
  logic        tx_we;
  logic [63:0] tx_dout;
  logic [7:0]  tx_size_out;
  logic        tx_free;
  logic        tx_filled;
  logic        tx_select;
  logic [63:0] rx_din;
  logic [8:0]  rx_adr;
  logic        rx_we;
  logic [63:0] rx_dout;
  logic [7:0]  rx_size_in;
  logic        rx_new;
  logic        rx_cleared;
  logic        rx_select;

  // buffer memories and the reference copies
  logic [63:0] tx_mem [512];
  logic [63:0] rx_mem [512];
  logic [63:0] tx_ref [512];
  logic [63:0] rx_ref [512];
  logic [15:0] mreg [16];
  logic        tx_sel_m;
  logic        rx_sel_m;
  integer      seed;
  int          errors;
  int          checks;
  int          tests;
  int          failed_tests;

  tb_clock_gen clock_gen (.clk_o(clk), .rst_o(rst));

  tge_cpu_attach uut (
    .wb_clk_i(clk), .wb_rst_i(rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_sel_i(wb_sel), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack), .local_mac_o(local_mac), .local_ip_o(local_ip),
    .local_gateway_o(local_gateway), .local_port_o(local_port), .local_valid_o(local_valid),
    .phy_status_i(phy_status), .mgt_rxeqmix_o(mgt_rxeqmix), .mgt_rxeqpole_o(mgt_rxeqpole),
    .mgt_txpreemphasis_o(mgt_txpreemphasis), .mgt_txdiffctrl_o(mgt_txdiffctrl),
    .tx_buffer_data_in_o(tx_din), .tx_buffer_address_o(tx_adr), .tx_buffer_we_o(tx_we),
    .tx_buffer_data_out_i(tx_dout), .tx_cpu_buffer_size_o(tx_size_out),
    .tx_cpu_free_buffer_i(tx_free), .tx_cpu_buffer_filled_o(tx_filled),
    .tx_cpu_buffer_select_i(tx_select), .rx_buffer_data_in_o(rx_din),
    .rx_buffer_address_o(rx_adr), .rx_buffer_we_o(rx_we), .rx_buffer_data_out_i(rx_dout),
    .rx_cpu_buffer_size_i(rx_size_in), .rx_cpu_new_buffer_i(rx_new),
    .rx_cpu_buffer_cleared_o(rx_cleared), .rx_cpu_buffer_select_i(rx_select)
  );

  function automatic logic [63:0] fill_word(input int i, input logic [15:0] salt);
    logic [15:0] a;
    a = 16'(i);
    return {a ^ salt, ~a, a + salt, a ^ 16'h5a5a};
  endfunction

  // asynchronous read and clocked write
  assign tx_dout = tx_mem[tx_adr];
  assign rx_dout = rx_mem[rx_adr];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 512; i++) begin
        tx_mem[i] <= fill_word(i, 16'h7a00);
        rx_mem[i] <= fill_word(i, 16'h3c00);
      end
    end else begin
      if (tx_we) tx_mem[tx_adr] <= tx_din;
      if (rx_we) rx_mem[rx_adr] <= rx_din;
    end
  end

  function automatic logic [15:0] reg_mask(input logic [3:0] idx);
    case (idx)
      REG_MAC_2, REG_MAC_1, REG_MAC_0: return 16'hffff;
      REG_IP_1, REG_IP_0, REG_UDP_PORT: return 16'hffff;
      REG_GATEWAY, REG_TX_SIZE, REG_RX_SIZE: return 16'h00ff;
      REG_VALID: return 16'h0001;
      // rxeqmix 1:0, rxeqpole 7:4, txpreemphasis 10:8, txdiffctrl 14:12
      REG_MGT_CONFIG: return 16'h77f3;
      default: return 16'h0000;
    endcase
  endfunction

  function automatic logic [31:0] buf_adr(input logic rx, input logic [7:0] word,
                                          input logic [1:0] lane);
    return (rx ? RX_BASE : TX_BASE) + {21'b0, word, lane, 1'b0};
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic init_model;
    for (int i = 0; i < 16; i++) begin
      mreg[i] = 16'h0000;
    end
    mreg[REG_MAC_2]      = DEFAULT_MAC[47:32];
    mreg[REG_MAC_1]      = DEFAULT_MAC[31:16];
    mreg[REG_MAC_0]      = DEFAULT_MAC[15:0];
    mreg[REG_GATEWAY]    = {8'h00, DEFAULT_GATEWAY};
    mreg[REG_IP_1]       = DEFAULT_IP[31:16];
    mreg[REG_IP_0]       = DEFAULT_IP[15:0];
    mreg[REG_VALID]      = {15'b0, DEFAULT_VALID};
    mreg[REG_UDP_PORT]   = DEFAULT_PORT;
    mreg[REG_MGT_CONFIG] = {1'b0, DEFAULT_TXDIFF, 1'b0, DEFAULT_TXPREEMPH, 8'h00};
    for (int i = 0; i < 512; i++) begin
      tx_ref[i] = fill_word(i, 16'h7a00);
      rx_ref[i] = fill_word(i, 16'h3c00);
    end
    tx_sel_m = 1'b0;
    rx_sel_m = 1'b0;
  endtask

  // one Wishbone cycle with data captured mid ack cycle
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [1:0] sel,
                           input logic [15:0] dat, output logic [15:0] rd);
    int   n;
    logic got;
    n = 0;
    got = 1'b0;
    rd = 16'h0000;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_sel   <= sel;
    wb_dat_w <= dat;
    while (!got && n < BUS_TIMEOUT) begin
      @(negedge clk);
      if (wb_ack) begin
        got = 1'b1;
        rd = wb_dat_r;
      end
      n++;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    assert (got) else begin
      errors++;
      $display("TIMEOUT at %0t ns: no acknowledge for the bus cycle at %h", $time, adr);
    end
  endtask

  task automatic reg_write(input logic [3:0] idx, input logic [1:0] sel, input logic [15:0] dat);
    logic [15:0] rd;
    logic [15:0] m;
    bus_cycle(1'b1, {27'b0, idx, 1'b0}, sel, dat, rd);
    m = reg_mask(idx) & {{8{sel[1]}}, {8{sel[0]}}};
    mreg[idx] = (mreg[idx] & ~m) | (dat & m);
  endtask

  task automatic reg_read_check(input logic [3:0] idx);
    logic [15:0] rd;
    logic [15:0] exp;
    bus_cycle(1'b0, {27'b0, idx, 1'b0}, 2'b11, 16'h0000, rd);
    exp = (idx == REG_PHY_STATUS) ? {8'h00, phy_status} : mreg[idx];
    check_val($sformatf("wb_dat_o (register %0d)", idx), 64'(rd), 64'(exp));
  endtask

  task automatic buf_write(input logic rx, input logic [7:0] word, input logic [1:0] lane,
                           input logic [1:0] sel, input logic [15:0] dat);
    logic [15:0] rd;
    logic [8:0]  a;
    logic [63:0] w;
    int          pos;
    bus_cycle(1'b1, buf_adr(rx, word, lane), sel, dat, rd);
    a = {(rx ? rx_sel_m : tx_sel_m), word};
    w = rx ? rx_ref[a] : tx_ref[a];
    pos = 16 * (3 - int'(lane));
    if (sel[0]) w[pos +: 8] = dat[7:0];
    if (sel[1]) w[pos + 8 +: 8] = dat[15:8];
    if (rx) rx_ref[a] = w;
    else tx_ref[a] = w;
  endtask

  task automatic buf_read_check(input logic rx, input logic [7:0] word, input logic [1:0] lane);
    logic [15:0] rd;
    logic [63:0] w;
    int          pos;
    bus_cycle(1'b0, buf_adr(rx, word, lane), 2'b11, 16'h0000, rd);
    w = rx ? rx_ref[{rx_sel_m, word}] : tx_ref[{tx_sel_m, word}];
    pos = 16 * (3 - int'(lane));
    check_val($sformatf("wb_dat_o (%s word %0d lane %0d)", rx ? "rx" : "tx", word, lane),
              64'(rd), 64'(w[pos +: 16]));
  endtask

  task automatic compare_mem;
    @(negedge clk);
    for (int i = 0; i < 512; i++) begin
      check_val($sformatf("tx buffer[%0d]", i), tx_mem[i], tx_ref[i]);
      check_val($sformatf("rx buffer[%0d]", i), rx_mem[i], rx_ref[i]);
    end
  endtask

  task automatic check_outputs;
    @(negedge clk);
    check_val("local_mac_o", 64'(local_mac),
              64'({mreg[REG_MAC_2], mreg[REG_MAC_1], mreg[REG_MAC_0]}));
    check_val("local_ip_o", 64'(local_ip), 64'({mreg[REG_IP_1], mreg[REG_IP_0]}));
    check_val("local_gateway_o", 64'(local_gateway), 64'(mreg[REG_GATEWAY][7:0]));
    check_val("local_port_o", 64'(local_port), 64'(mreg[REG_UDP_PORT]));
    check_val("local_valid_o", 64'(local_valid), 64'(mreg[REG_VALID][0]));
    check_val("mgt_rxeqmix_o", 64'(mgt_rxeqmix), 64'(mreg[REG_MGT_CONFIG][1:0]));
    check_val("mgt_rxeqpole_o", 64'(mgt_rxeqpole), 64'(mreg[REG_MGT_CONFIG][7:4]));
    check_val("mgt_txpreemphasis_o", 64'(mgt_txpreemphasis), 64'(mreg[REG_MGT_CONFIG][10:8]));
    check_val("mgt_txdiffctrl_o", 64'(mgt_txdiffctrl), 64'(mreg[REG_MGT_CONFIG][14:12]));
  endtask

  // rx_side picks cleared instead of filled
  task automatic wait_level(input logic rx_side, input logic level, input string what);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < HS_TIMEOUT) begin
      @(negedge clk);
      seen = rx_side ? (rx_cleared == level) : (tx_filled == level);
      n++;
    end
    assert (seen) else begin
      errors++;
      $display("TIMEOUT at %0t ns: %s did not happen", $time, what);
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, errors - start_errors);
    end
  endtask

  initial begin
    int          start;
    int          n;
    logic [3:0]  idx;
    logic        rx_bit;
    logic        sel_bit;
    logic [7:0]  size;
    logic [7:0]  word;
    logic [1:0]  lane;
    seed = 32'hb15e61c5;
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    wb_cyc     <= 1'b0;
    wb_stb     <= 1'b0;
    wb_we      <= 1'b0;
    wb_sel     <= 2'b00;
    wb_adr     <= 32'h0;
    wb_dat_w   <= 16'h0;
    phy_status <= 8'h00;
    tx_free    <= 1'b0;
    tx_select  <= 1'b0;
    rx_new     <= 1'b0;
    rx_size_in <= 8'h00;
    rx_select  <= 1'b0;
    init_model();
    n = 0;
    while (rst !== 1'b0 && n < 100) begin
      @(posedge clk);
      n++;
    end
    assert (rst === 1'b0) else begin
      errors++;
      $display("reset was never released");
    end

    start = errors;
    for (int i = 0; i < 16; i++) begin
      reg_read_check(4'(i));
    end
    check_outputs();
    end_test("reset_defaults", start);

    start = errors;
    for (int k = 0; k < 60; k++) begin
      idx = 4'($random(seed));
      if (k % 8 == 0) begin
        @(posedge clk);
        phy_status <= 8'($random(seed));
      end
      if ($random(seed) & 1) begin
        reg_write(idx, 2'($random(seed)), 16'($random(seed)));
        check_outputs();
      end else begin
        reg_read_check(idx);
      end
    end
    for (int i = 0; i < 16; i++) begin
      reg_read_check(4'(i));
    end
    end_test("random_registers", start);

    start = errors;
    for (int k = 0; k < 80; k++) begin
      rx_bit = 1'($random(seed));
      word = 8'($random(seed));
      lane = 2'($random(seed));
      buf_write(rx_bit, word, lane, 2'($random(seed)), 16'($random(seed)));
      buf_read_check(rx_bit, word, 2'($random(seed)));
    end
    compare_mem();
    end_test("random_buffers", start);

    // free edge zeroes the size before the cpu fills the buffer
    start = errors;
    sel_bit = ~tx_sel_m;
    size = 8'($random(seed)) | 8'h01;
    reg_write(REG_TX_SIZE, 2'b01, {8'h00, 8'($random(seed)) | 8'h01});
    @(posedge clk);
    tx_free   <= 1'b1;
    tx_select <= sel_bit;
    tx_sel_m = sel_bit;
    mreg[REG_TX_SIZE] = 16'h0000;
    reg_read_check(REG_TX_SIZE);
    check_val("tx_cpu_buffer_filled_o", 64'(tx_filled), 64'(0));
    word = 8'($random(seed));
    lane = 2'($random(seed));
    buf_write(1'b0, word, lane, 2'b11, 16'($random(seed)));
    buf_read_check(1'b0, word, lane);
    reg_write(REG_TX_SIZE, 2'b11, {8'($random(seed)), size});
    wait_level(1'b0, 1'b1, "rise of tx_cpu_buffer_filled_o");
    check_val("tx_cpu_buffer_size_o", 64'(tx_size_out), 64'(size));
    reg_read_check(REG_TX_SIZE);
    @(posedge clk);
    tx_free <= 1'b0;
    wait_level(1'b0, 1'b0, "fall of tx_cpu_buffer_filled_o");
    reg_read_check(REG_TX_SIZE);
    compare_mem();
    end_test("tx_handshake", start);

    start = errors;
    sel_bit = 1'($random(seed));
    size = 8'($random(seed)) | 8'h01;
    @(posedge clk);
    rx_new     <= 1'b1;
    rx_size_in <= size;
    rx_select  <= sel_bit;
    rx_sel_m = sel_bit;
    mreg[REG_RX_SIZE] = {8'h00, size};
    reg_read_check(REG_RX_SIZE);
    word = 8'($random(seed));
    lane = 2'($random(seed));
    buf_write(1'b1, word, lane, 2'($random(seed)), 16'($random(seed)));
    buf_read_check(1'b1, word, lane);
    check_val("rx_cpu_buffer_cleared_o", 64'(rx_cleared), 64'(0));
    // size written to zero hands the buffer back
    reg_write(REG_RX_SIZE, 2'b01, 16'h0000);
    wait_level(1'b1, 1'b1, "rise of rx_cpu_buffer_cleared_o");
    @(posedge clk);
    rx_new <= 1'b0;
    wait_level(1'b1, 1'b0, "fall of rx_cpu_buffer_cleared_o");
    compare_mem();
    end_test("rx_handshake", start);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- source/tge_buffer_ctrl.sv
`timescale 1ns/10ps

module tge_buffer_ctrl (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  reg_we_i,
  input  tge_cpu_pkg::reg_idx_t reg_idx_i,
  input  logic [1:0]            wb_sel_i,
  input  tge_cpu_pkg::wb_data_t wb_dat_i,
  input  logic                  tx_cpu_free_buffer_i,
  input  logic                  tx_cpu_buffer_select_i,
  input  logic                  rx_cpu_new_buffer_i,
  input  logic [7:0]            rx_cpu_buffer_size_i,
  input  logic                  rx_cpu_buffer_select_i,
  output logic [7:0]            tx_size_o,
  output logic [7:0]            rx_size_o,
  output logic                  tx_sel_o,
  output logic                  rx_sel_o,
  output logic [7:0]            tx_cpu_buffer_size_o,
  output logic                  tx_cpu_buffer_filled_o,
  output logic                  rx_cpu_buffer_cleared_o
);
  import tge_cpu_pkg::*;

  logic free_q;
  logic new_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      free_q                  <= 1'b0;
      new_q                   <= 1'b0;
      tx_size_o               <= '0;
      rx_size_o               <= '0;
      tx_sel_o                <= 1'b0;
      rx_sel_o                <= 1'b0;
      tx_cpu_buffer_filled_o  <= 1'b0;
      rx_cpu_buffer_cleared_o <= 1'b0;
    end else begin
      free_q <= tx_cpu_free_buffer_i;
      new_q  <= rx_cpu_new_buffer_i;

      // tx: buffer handed to the cpu on the rising edge of free
      if (!tx_cpu_buffer_filled_o && tx_cpu_free_buffer_i && !free_q) begin
        tx_size_o <= '0;
        tx_sel_o  <= tx_cpu_buffer_select_i;
      end
      // cpu has written a size, hand it back
      if (!tx_cpu_buffer_filled_o && tx_cpu_free_buffer_i && free_q && tx_size_o != '0) begin
        tx_cpu_buffer_filled_o <= 1'b1;
      end
      if (tx_cpu_buffer_filled_o && !tx_cpu_free_buffer_i) begin
        tx_cpu_buffer_filled_o <= 1'b0;
      end

      // rx: new packet arrives with its size
      if (!rx_cpu_buffer_cleared_o && rx_cpu_new_buffer_i && !new_q) begin
        rx_size_o <= rx_cpu_buffer_size_i;
        rx_sel_o  <= rx_cpu_buffer_select_i;
      end
      // size zeroed by the cpu means the packet is consumed
      if (!rx_cpu_buffer_cleared_o && rx_cpu_new_buffer_i && new_q && rx_size_o == '0) begin
        rx_cpu_buffer_cleared_o <= 1'b1;
      end
      if (rx_cpu_buffer_cleared_o && !rx_cpu_new_buffer_i) begin
        rx_cpu_buffer_cleared_o <= 1'b0;
      end

      // cpu writes come last and win
      if (reg_we_i && wb_sel_i[0]) begin
        if (reg_idx_i == REG_TX_SIZE) tx_size_o <= wb_dat_i[7:0];
        if (reg_idx_i == REG_RX_SIZE) rx_size_o <= wb_dat_i[7:0];
      end
    end
  end

  // size toward the mac side, captured as filled rises
  always_ff @(posedge wb_clk_i) begin
    if (!tx_cpu_buffer_filled_o && tx_cpu_free_buffer_i && free_q && tx_size_o != '0) begin
      tx_cpu_buffer_size_o <= tx_size_o;
    end
  end

endmodule

//--- source/tge_buffer_port.sv
`timescale 1ns/10ps

module tge_buffer_port (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   we_i,
  input  tge_cpu_pkg::lane_t     lane_i,
  input  logic [1:0]             wb_sel_i,
  input  tge_cpu_pkg::wb_data_t  wb_dat_i,
  input  tge_cpu_pkg::wb_adr_t   wb_adr_i,
  input  logic                   sel_i,
  input  tge_cpu_pkg::buf_word_t buf_dat_i,
  output tge_cpu_pkg::buf_adr_t  buf_adr_o,
  output tge_cpu_pkg::buf_word_t buf_dat_o,
  output logic                   buf_we_o,
  output tge_cpu_pkg::wb_data_t  rd_lane_o
);
  import tge_cpu_pkg::*;

  buf_word_t merged;

  // word index within the 2 KB window, select bit on top
  assign buf_adr_o = {sel_i, wb_adr_i[10:3]};

  // replace the selected bytes of the addressed lane
  always_comb begin
    merged = buf_dat_i;
    for (int i = 0; i < 4; i++) begin
      if (lane_i == lane_t'(3 - i)) begin
        if (wb_sel_i[0]) merged[16*i +: 8]     = wb_dat_i[7:0];
        if (wb_sel_i[1]) merged[16*i + 8 +: 8] = wb_dat_i[15:8];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (we_i) begin
      buf_dat_o <= merged;
    end
  end

  // write lands with ack, address still held by the master
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      buf_we_o <= 1'b0;
    end else begin
      buf_we_o <= we_i;
    end
  end

  always_comb begin
    case (lane_i)
      2'd0:    rd_lane_o = buf_dat_i[63:48];
      2'd1:    rd_lane_o = buf_dat_i[47:32];
      2'd2:    rd_lane_o = buf_dat_i[31:16];
      default: rd_lane_o = buf_dat_i[15:0];
    endcase
  end

endmodule

//--- source/tge_cpu_attach.sv
`timescale 1ns/10ps

module tge_cpu_attach (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [1:0]             wb_sel_i,
  input  tge_cpu_pkg::wb_adr_t   wb_adr_i,
  input  tge_cpu_pkg::wb_data_t  wb_dat_i,
  output tge_cpu_pkg::wb_data_t  wb_dat_o,
  output logic                   wb_ack_o,
  // local configuration
  output logic [47:0]            local_mac_o,
  output logic [31:0]            local_ip_o,
  output logic [7:0]             local_gateway_o,
  output logic [15:0]            local_port_o,
  output logic                   local_valid_o,
  input  logic [7:0]             phy_status_i,
  output logic [1:0]             mgt_rxeqmix_o,
  output logic [3:0]             mgt_rxeqpole_o,
  output logic [2:0]             mgt_txpreemphasis_o,
  output logic [2:0]             mgt_txdiffctrl_o,
  // tx buffer
  output tge_cpu_pkg::buf_word_t tx_buffer_data_in_o,
  output tge_cpu_pkg::buf_adr_t  tx_buffer_address_o,
  output logic                   tx_buffer_we_o,
  input  tge_cpu_pkg::buf_word_t tx_buffer_data_out_i,
  output logic [7:0]             tx_cpu_buffer_size_o,
  input  logic                   tx_cpu_free_buffer_i,
  output logic                   tx_cpu_buffer_filled_o,
  input  logic                   tx_cpu_buffer_select_i,
  // rx buffer
  output tge_cpu_pkg::buf_word_t rx_buffer_data_in_o,
  output tge_cpu_pkg::buf_adr_t  rx_buffer_address_o,
  output logic                   rx_buffer_we_o,
  input  tge_cpu_pkg::buf_word_t rx_buffer_data_out_i,
  input  logic [7:0]             rx_cpu_buffer_size_i,
  input  logic                   rx_cpu_new_buffer_i,
  output logic                   rx_cpu_buffer_cleared_o,
  input  logic                   rx_cpu_buffer_select_i
);
  import tge_cpu_pkg::*;

  win_t     win;
  lane_t    lane;
  reg_idx_t reg_idx;
  logic     reg_we;
  logic     tx_we;
  logic     rx_we;
  logic     tx_sel;
  logic     rx_sel;
  logic [7:0] tx_size;
  logic [7:0] rx_size;
  wb_data_t tx_lane;
  wb_data_t rx_lane;

  tge_wb_decode decode (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i,
    .ack_o(wb_ack_o), .win_o(win), .reg_we_o(reg_we), .tx_we_o(tx_we),
    .rx_we_o(rx_we), .lane_o(lane), .reg_idx_o(reg_idx)
  );

  tge_reg_file reg_file (
    .wb_clk_i, .wb_rst_i, .reg_we_i(reg_we), .reg_idx_i(reg_idx), .wb_sel_i, .wb_dat_i,
    .local_mac_o, .local_ip_o, .local_gateway_o, .local_port_o, .local_valid_o,
    .mgt_rxeqmix_o, .mgt_rxeqpole_o, .mgt_txpreemphasis_o, .mgt_txdiffctrl_o
  );

  tge_buffer_ctrl buffer_ctrl (
    .wb_clk_i, .wb_rst_i, .reg_we_i(reg_we), .reg_idx_i(reg_idx), .wb_sel_i, .wb_dat_i,
    .tx_cpu_free_buffer_i, .tx_cpu_buffer_select_i, .rx_cpu_new_buffer_i,
    .rx_cpu_buffer_size_i, .rx_cpu_buffer_select_i,
    .tx_size_o(tx_size), .rx_size_o(rx_size), .tx_sel_o(tx_sel), .rx_sel_o(rx_sel),
    .tx_cpu_buffer_size_o, .tx_cpu_buffer_filled_o, .rx_cpu_buffer_cleared_o
  );

  tge_buffer_port tx_port (
    .wb_clk_i, .wb_rst_i, .we_i(tx_we), .lane_i(lane), .wb_sel_i, .wb_dat_i, .wb_adr_i,
    .sel_i(tx_sel), .buf_dat_i(tx_buffer_data_out_i), .buf_adr_o(tx_buffer_address_o),
    .buf_dat_o(tx_buffer_data_in_o), .buf_we_o(tx_buffer_we_o), .rd_lane_o(tx_lane)
  );

  tge_buffer_port rx_port (
    .wb_clk_i, .wb_rst_i, .we_i(rx_we), .lane_i(lane), .wb_sel_i, .wb_dat_i, .wb_adr_i,
    .sel_i(rx_sel), .buf_dat_i(rx_buffer_data_out_i), .buf_adr_o(rx_buffer_address_o),
    .buf_dat_o(rx_buffer_data_in_o), .buf_we_o(rx_buffer_we_o), .rd_lane_o(rx_lane)
  );

  tge_wb_result result (
    .wb_clk_i, .wb_rst_i, .win_i(win), .reg_idx_i(reg_idx),
    .local_mac_i(local_mac_o), .local_ip_i(local_ip_o), .local_gateway_i(local_gateway_o),
    .local_port_i(local_port_o), .local_valid_i(local_valid_o),
    .mgt_rxeqmix_i(mgt_rxeqmix_o), .mgt_rxeqpole_i(mgt_rxeqpole_o),
    .mgt_txpreemphasis_i(mgt_txpreemphasis_o), .mgt_txdiffctrl_i(mgt_txdiffctrl_o),
    .tx_size_i(tx_size), .rx_size_i(rx_size), .phy_status_i,
    .tx_lane_i(tx_lane), .rx_lane_i(rx_lane), .wb_dat_o
  );

endmodule

//--- source/tge_cpu_pkg.sv
package tge_cpu_pkg;

  // bus and buffer word types
  typedef logic [15:0] wb_data_t;
  typedef logic [31:0] wb_adr_t;
  typedef logic [63:0] buf_word_t;
  // select bit above the word index
  typedef logic [8:0]  buf_adr_t;
  // lane 3 is the low half word
  typedef logic [1:0]  lane_t;
  typedef logic [3:0]  reg_idx_t;

  typedef enum logic [1:0] {
    WIN_NONE,
    WIN_REGS,
    WIN_TX,
    WIN_RX
  } win_t;

  // address windows, each 2 KB aligned
  localparam wb_adr_t REGS_BASE = 32'h0000_0000;
  localparam wb_adr_t REGS_HIGH = 32'h0000_07FF;
  localparam wb_adr_t TX_BASE   = 32'h0000_1000;
  localparam wb_adr_t TX_HIGH   = 32'h0000_17FF;
  localparam wb_adr_t RX_BASE   = 32'h0000_2000;
  localparam wb_adr_t RX_HIGH   = 32'h0000_27FF;

  // index 0 and 4 are kept free for compatibility
  localparam reg_idx_t REG_MAC_2      = 4'd1;
  localparam reg_idx_t REG_MAC_1      = 4'd2;
  localparam reg_idx_t REG_MAC_0      = 4'd3;
  localparam reg_idx_t REG_GATEWAY    = 4'd5;
  localparam reg_idx_t REG_IP_1       = 4'd6;
  localparam reg_idx_t REG_IP_0       = 4'd7;
  localparam reg_idx_t REG_TX_SIZE    = 4'd8;
  localparam reg_idx_t REG_RX_SIZE    = 4'd9;
  localparam reg_idx_t REG_VALID      = 4'd10;
  localparam reg_idx_t REG_UDP_PORT   = 4'd11;
  localparam reg_idx_t REG_PHY_STATUS = 4'd12;
  localparam reg_idx_t REG_MGT_CONFIG = 4'd13;

  localparam logic [47:0] DEFAULT_MAC       = 48'hffff_ffff_ffff;
  localparam logic [31:0] DEFAULT_IP        = 32'hffff_ffff;
  localparam logic [7:0]  DEFAULT_GATEWAY   = 8'hff;
  localparam logic [15:0] DEFAULT_PORT      = 16'hffff;
  localparam logic        DEFAULT_VALID     = 1'b1;
  localparam logic [2:0]  DEFAULT_TXPREEMPH = 3'd7;
  localparam logic [2:0]  DEFAULT_TXDIFF    = 3'd4;

endpackage

//--- source/tge_reg_file.sv
`timescale 1ns/10ps

module tge_reg_file (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  reg_we_i,
  input  tge_cpu_pkg::reg_idx_t reg_idx_i,
  input  logic [1:0]            wb_sel_i,
  input  tge_cpu_pkg::wb_data_t wb_dat_i,
  output logic [47:0]           local_mac_o,
  output logic [31:0]           local_ip_o,
  output logic [7:0]            local_gateway_o,
  output logic [15:0]           local_port_o,
  output logic                  local_valid_o,
  output logic [1:0]            mgt_rxeqmix_o,
  output logic [3:0]            mgt_rxeqpole_o,
  output logic [2:0]            mgt_txpreemphasis_o,
  output logic [2:0]            mgt_txdiffctrl_o
);
  import tge_cpu_pkg::*;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      local_mac_o         <= DEFAULT_MAC;
      local_ip_o          <= DEFAULT_IP;
      local_gateway_o     <= DEFAULT_GATEWAY;
      local_port_o        <= DEFAULT_PORT;
      local_valid_o       <= DEFAULT_VALID;
      // equalizer starts neutral
      mgt_rxeqmix_o       <= '0;
      mgt_rxeqpole_o      <= '0;
      mgt_txpreemphasis_o <= DEFAULT_TXPREEMPH;
      mgt_txdiffctrl_o    <= DEFAULT_TXDIFF;
    end else if (reg_we_i) begin
      case (reg_idx_i)
        REG_MAC_2: begin
          if (wb_sel_i[0]) local_mac_o[39:32] <= wb_dat_i[7:0];
          if (wb_sel_i[1]) local_mac_o[47:40] <= wb_dat_i[15:8];
        end
        REG_MAC_1: begin
          if (wb_sel_i[0]) local_mac_o[23:16] <= wb_dat_i[7:0];
          if (wb_sel_i[1]) local_mac_o[31:24] <= wb_dat_i[15:8];
        end
        REG_MAC_0: begin
          if (wb_sel_i[0]) local_mac_o[7:0]  <= wb_dat_i[7:0];
          if (wb_sel_i[1]) local_mac_o[15:8] <= wb_dat_i[15:8];
        end
        // low byte only
        REG_GATEWAY: begin
          if (wb_sel_i[0]) local_gateway_o <= wb_dat_i[7:0];
        end
        REG_IP_1: begin
          if (wb_sel_i[0]) local_ip_o[23:16] <= wb_dat_i[7:0];
          if (wb_sel_i[1]) local_ip_o[31:24] <= wb_dat_i[15:8];
        end
        REG_IP_0: begin
          if (wb_sel_i[0]) local_ip_o[7:0]  <= wb_dat_i[7:0];
          if (wb_sel_i[1]) local_ip_o[15:8] <= wb_dat_i[15:8];
        end
        REG_VALID: begin
          if (wb_sel_i[0]) local_valid_o <= wb_dat_i[0];
        end
        REG_UDP_PORT: begin
          if (wb_sel_i[0]) local_port_o[7:0]  <= wb_dat_i[7:0];
          if (wb_sel_i[1]) local_port_o[15:8] <= wb_dat_i[15:8];
        end
        REG_MGT_CONFIG: begin
          if (wb_sel_i[0]) begin
            mgt_rxeqmix_o  <= wb_dat_i[1:0];
            mgt_rxeqpole_o <= wb_dat_i[7:4];
          end
          if (wb_sel_i[1]) begin
            mgt_txpreemphasis_o <= wb_dat_i[10:8];
            mgt_txdiffctrl_o    <= wb_dat_i[14:12];
          end
        end
        // sizes live in buffer_ctrl, phy status is read only
        default: begin
        end
      endcase
    end
  end

endmodule

//--- source/tge_wb_decode.sv
`timescale 1ns/10ps

module tge_wb_decode (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  tge_cpu_pkg::wb_adr_t  wb_adr_i,
  output logic                  ack_o,
  output tge_cpu_pkg::win_t     win_o,
  output logic                  reg_we_o,
  output logic                  tx_we_o,
  output logic                  rx_we_o,
  output tge_cpu_pkg::lane_t    lane_o,
  output tge_cpu_pkg::reg_idx_t reg_idx_o
);
  import tge_cpu_pkg::*;

  logic trans;

  function automatic logic in_win(input wb_adr_t adr, input wb_adr_t lo, input wb_adr_t hi);
    return (adr >= lo) && (adr <= hi);
  endfunction

  // one transaction per strobe, blocked while acknowledging
  assign trans = wb_stb_i & wb_cyc_i & ~ack_o;

  always_comb begin
    win_o = WIN_NONE;
    if (trans) begin
      if (in_win(wb_adr_i, REGS_BASE, REGS_HIGH)) begin
        win_o = WIN_REGS;
      end else if (in_win(wb_adr_i, TX_BASE, TX_HIGH)) begin
        win_o = WIN_TX;
      end else if (in_win(wb_adr_i, RX_BASE, RX_HIGH)) begin
        win_o = WIN_RX;
      end
    end
  end

  // bases are 2 KB aligned so the offset bits are the address bits
  assign reg_idx_o = wb_adr_i[4:1];
  assign lane_o    = wb_adr_i[2:1];

  assign reg_we_o = wb_we_i && (win_o == WIN_REGS);
  assign tx_we_o  = wb_we_i && (win_o == WIN_TX);
  assign rx_we_o  = wb_we_i && (win_o == WIN_RX);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= trans;
    end
  end

endmodule

//--- source/tge_wb_result.sv
`timescale 1ns/10ps

module tge_wb_result (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  tge_cpu_pkg::win_t     win_i,
  input  tge_cpu_pkg::reg_idx_t reg_idx_i,
  input  logic [47:0]           local_mac_i,
  input  logic [31:0]           local_ip_i,
  input  logic [7:0]            local_gateway_i,
  input  logic [15:0]           local_port_i,
  input  logic                  local_valid_i,
  input  logic [1:0]            mgt_rxeqmix_i,
  input  logic [3:0]            mgt_rxeqpole_i,
  input  logic [2:0]            mgt_txpreemphasis_i,
  input  logic [2:0]            mgt_txdiffctrl_i,
  input  logic [7:0]            tx_size_i,
  input  logic [7:0]            rx_size_i,
  input  logic [7:0]            phy_status_i,
  input  tge_cpu_pkg::wb_data_t tx_lane_i,
  input  tge_cpu_pkg::wb_data_t rx_lane_i,
  output tge_cpu_pkg::wb_data_t wb_dat_o
);
  import tge_cpu_pkg::*;

  win_t     src_win;
  reg_idx_t src_idx;
  wb_data_t reg_dat;

  // source captured at the transaction, used during ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      src_win <= WIN_NONE;
    end else begin
      src_win <= win_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    src_idx <= reg_idx_i;
  end

  always_comb begin
    case (src_idx)
      REG_MAC_2:      reg_dat = local_mac_i[47:32];
      REG_MAC_1:      reg_dat = local_mac_i[31:16];
      REG_MAC_0:      reg_dat = local_mac_i[15:0];
      REG_GATEWAY:    reg_dat = {8'b0, local_gateway_i};
      REG_IP_1:       reg_dat = local_ip_i[31:16];
      REG_IP_0:       reg_dat = local_ip_i[15:0];
      REG_TX_SIZE:    reg_dat = {8'b0, tx_size_i};
      REG_RX_SIZE:    reg_dat = {8'b0, rx_size_i};
      REG_VALID:      reg_dat = {15'b0, local_valid_i};
      REG_UDP_PORT:   reg_dat = local_port_i;
      REG_PHY_STATUS: reg_dat = {8'b0, phy_status_i};
      REG_MGT_CONFIG: reg_dat = {1'b0, mgt_txdiffctrl_i, 1'b0, mgt_txpreemphasis_i,
                                 mgt_rxeqpole_i, 2'b0, mgt_rxeqmix_i};
      default:        reg_dat = '0;
    endcase
  end

  always_comb begin
    case (src_win)
      WIN_REGS: wb_dat_o = reg_dat;
      WIN_TX:   wb_dat_o = tx_lane_i;
      WIN_RX:   wb_dat_o = rx_lane_i;
      default:  wb_dat_o = '0;
    endcase
  end

endmodule

//--- src.f
source/tge_cpu_pkg.sv
source/tge_wb_decode.sv
source/tge_reg_file.sv
source/tge_buffer_ctrl.sv
source/tge_buffer_port.sv
source/tge_wb_result.sv
source/tge_cpu_attach.sv
sim/tb_clock_gen.sv
sim/tge_cpu_attach_assert.sv
sim/tge_cpu_attach_tb.sv
